// File: src/front_config.svh
`ifndef FRONT_CONFIG_SVH
`define FRONT_CONFIG_SVH

// integer register and address width
`define XLEN 64

// first fetch address after reset
`define PC_RESET_ADDR 64'h0000_0000_8000_0000

// buffer slots between the fetch master and the predecoder
`define SLOT_COUNT 3

// major opcode of jal, instr[6:0]
`define OPC_JAL 7'b110_1111

`endif

// File: src/front_pkg.sv
`include "front_config.svh"

package front_pkg;

  // generic pc redirect, used for branch and jal
  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] target;
  } redirect_t;

  // trap redirect from the memory stage
  typedef struct packed {
    logic             valid;
    logic             fencei;  // resume at target + 4
    logic [`XLEN-1:0] target;
  } trap_redirect_t;

  // one fetched instruction and where it came from
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [31:0]      instr;
  } fetch_pkt_t;

  // wishbone classic master outputs
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [`XLEN-1:0] adr;
    logic [3:0]       sel;
  } wb_req_t;

  // wishbone classic slave answer
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

// File: src/pc_gen.sv
`include "front_config.svh"

module pc_gen import front_pkg::*; (
  input  logic             clk,
  input  logic             rst_n_i,
  input  redirect_t        branch_i,          // from execute
  input  trap_redirect_t   trap_i,            // from memory stage
  input  redirect_t        jal_i,             // from the predecoder
  input  logic             fetch_accept_i,    // packet pushed into slot 0
  output logic [`XLEN-1:0] pc_o,
  output logic             redirect_taken_o
);

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] pc_next;
  logic [`XLEN-1:0] add_base;
  logic [`XLEN-1:0] add_base_plus4;
  logic             pc_wen;

  // one adder serves both sequential fetch and the fence.i resume
  assign add_base       = (trap_i.valid && trap_i.fencei) ? trap_i.target : pc_q;
  assign add_base_plus4 = add_base + `XLEN'd4;

  // older stages win: trap, then branch, then jal
  always_comb begin
    if (trap_i.valid && trap_i.fencei) begin
      pc_next = add_base_plus4;
    end else if (trap_i.valid) begin
      pc_next = trap_i.target;
    end else if (branch_i.valid) begin
      pc_next = branch_i.target;
    end else if (jal_i.valid) begin
      pc_next = jal_i.target;
    end else begin
      pc_next = add_base_plus4;  // sequential
    end
  end

  assign redirect_taken_o = trap_i.valid || branch_i.valid || jal_i.valid;

  // hold while the fetch is not yet accepted downstream
  assign pc_wen = redirect_taken_o || fetch_accept_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= `PC_RESET_ADDR;
    end else if (pc_wen) begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

endmodule

// File: src/fetch_wb_master.sv
`include "front_config.svh"

module fetch_wb_master import front_pkg::*; (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic [`XLEN-1:0] pc_i,
  input  logic             flush_i,         // redirect taken this cycle
  input  wb_rsp_t          wb_rsp_i,
  input  logic             pkt_ready_i,     // slot 0 can take a packet
  output wb_req_t          wb_req_o,
  output fetch_pkt_t       pkt_o,
  output logic             pkt_valid_o,
  output logic             fetch_accept_o
);

  typedef enum logic [1:0] {
    FS_IDLE,  // bus quiet, may start next cycle
    FS_BUSY,  // cyc and stb up, waiting for ack
    FS_HOLD   // data returned but slot 0 was full
  } fetch_state_e;

  fetch_state_e     state_q;
  logic             req_q;
  logic             stale_q;     // a redirect passed during this cycle
  logic [`XLEN-1:0] adr_q;       // also the pc of the packet
  logic [31:0]      instr_q;
  logic             ack_live;
  logic             start;

  // never start on a redirect edge, pc_i is still the old value there
  assign start = (state_q == FS_IDLE) && !flush_i;

  // a response counts only if no redirect touched this cycle
  assign ack_live = (state_q == FS_BUSY) && wb_rsp_i.ack && !stale_q && !flush_i;

  always_comb begin
    pkt_o.pc    = adr_q;
    pkt_o.instr = (state_q == FS_HOLD) ? instr_q : wb_rsp_i.dat;
  end

  assign pkt_valid_o    = ack_live || ((state_q == FS_HOLD) && !flush_i);
  assign fetch_accept_o = pkt_valid_o && pkt_ready_i;

  // read only, full word lanes
  always_comb begin
    wb_req_o.cyc = req_q;
    wb_req_o.stb = req_q;
    wb_req_o.we  = 1'b0;
    wb_req_o.adr = adr_q;
    wb_req_o.sel = 4'hf;
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= FS_IDLE;
      req_q   <= 1'b0;
      stale_q <= 1'b0;
    end else begin
      case (state_q)
        FS_IDLE: begin
          if (start) begin
            state_q <= FS_BUSY;
            req_q   <= 1'b1;
            stale_q <= 1'b0;
          end
        end
        FS_BUSY: begin
          if (wb_rsp_i.ack) begin
            req_q   <= 1'b0;  // stb drops at least one cycle
            state_q <= (ack_live && !pkt_ready_i) ? FS_HOLD : FS_IDLE;
          end else if (flush_i) begin
            stale_q <= 1'b1;  // classic bus cannot abort, just drop the data
          end
        end
        FS_HOLD: begin
          // leave on push, or drop the packet on a redirect
          if (flush_i || pkt_ready_i) begin
            state_q <= FS_IDLE;
          end
        end
        default: state_q <= FS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      adr_q <= pc_i;
    end
    if (ack_live && !pkt_ready_i) begin
      instr_q <= wb_rsp_i.dat;  // back-pressure, keep the word
    end
  end

endmodule

// File: src/pipe_slot.sv
module pipe_slot #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     flush_i,
  input  payload_t in_i,
  input  logic     in_valid_i,
  input  logic     out_ready_i,
  output logic     in_ready_o,
  output payload_t out_o,
  output logic     out_valid_o
);

  logic     valid_q;
  payload_t data_q;

  // free slot, or the item leaves this cycle
  assign in_ready_o = !valid_q || out_ready_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;  // also beats a push on the same edge
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_i;
    end
  end

  assign out_o       = data_q;
  assign out_valid_o = valid_q;

endmodule

// File: src/jal_predecode.sv
`include "front_config.svh"

module jal_predecode import front_pkg::*; (
  input  logic       clk,
  input  logic       rst_n_i,
  input  fetch_pkt_t head_i,          // last slot of the chain
  input  logic       head_valid_i,
  input  logic       issue_ready_i,   // decode stage can take it
  input  logic       ext_redirect_i,  // branch or trap this cycle
  output logic       head_ready_o,
  output fetch_pkt_t issue_o,
  output logic       issue_valid_o,
  output redirect_t  jal_o
);

  logic             settle_q;  // one cycle after a jal redirect
  logic             issue_en;
  logic             is_jal;
  logic [`XLEN-1:0] jal_imm;

  assign is_jal = (head_i.instr[6:0] == `OPC_JAL);

  // J-type immediate, sign extended to XLEN
  assign jal_imm = {
    {(`XLEN - 21){head_i.instr[31]}},
    head_i.instr[31],
    head_i.instr[19:12],
    head_i.instr[20],
    head_i.instr[30:21],
    1'b0
  };

  // older redirects own this cycle, the head is younger
  assign issue_en = !ext_redirect_i && !settle_q;

  assign issue_o       = head_i;
  assign issue_valid_o = head_valid_i && issue_en;
  assign head_ready_o  = issue_ready_i && issue_en;  // only pop what is issued

  // redirect together with the jal issue itself
  assign jal_o.valid  = issue_valid_o && issue_ready_i && is_jal;
  assign jal_o.target = head_i.pc + jal_imm;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      settle_q <= 1'b0;
    end else begin
      settle_q <= jal_o.valid;
    end
  end

endmodule

// File: src/front_end_top.sv
`include "front_config.svh"

module front_end_top import front_pkg::*; (
  input  logic           clk,
  input  logic           rst_n_i,
  input  redirect_t      branch_i,
  input  trap_redirect_t trap_i,
  output wb_req_t        wb_req_o,
  input  wb_rsp_t        wb_rsp_i,
  output fetch_pkt_t     issue_o,
  output logic           issue_valid_o,
  input  logic           issue_ready_i
);

  logic [`XLEN-1:0]    pc;
  logic                redirect_taken;
  logic                fetch_accept;
  logic                slot_flush;
  logic                ext_redirect;
  redirect_t           jal_redirect;

  // chain index 0 is the fetch master, k+1 the output of slot k
  fetch_pkt_t          chain_data [`SLOT_COUNT + 1];
  logic [`SLOT_COUNT:0] chain_valid;
  logic [`SLOT_COUNT:0] chain_ready;

  assign ext_redirect = branch_i.valid || trap_i.valid;
  assign slot_flush   = redirect_taken || jal_redirect.valid;

  pc_gen u_pc_gen (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .branch_i         (branch_i),
    .trap_i           (trap_i),
    .jal_i            (jal_redirect),
    .fetch_accept_i   (fetch_accept),
    .pc_o             (pc),
    .redirect_taken_o (redirect_taken)
  );

  fetch_wb_master u_fetch (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .pc_i           (pc),
    .flush_i        (redirect_taken),
    .wb_rsp_i       (wb_rsp_i),
    .pkt_ready_i    (chain_ready[0]),
    .wb_req_o       (wb_req_o),
    .pkt_o          (chain_data[0]),
    .pkt_valid_o    (chain_valid[0]),
    .fetch_accept_o (fetch_accept)
  );

  for (genvar k = 0; k < `SLOT_COUNT; k++) begin : g_slot
    pipe_slot #(
      .payload_t (fetch_pkt_t)
    ) u_slot (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .flush_i     (slot_flush),
      .in_i        (chain_data[k]),
      .in_valid_i  (chain_valid[k]),
      .out_ready_i (chain_ready[k + 1]),
      .in_ready_o  (chain_ready[k]),
      .out_o       (chain_data[k + 1]),
      .out_valid_o (chain_valid[k + 1])
    );
  end

  jal_predecode u_predecode (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .head_i         (chain_data[`SLOT_COUNT]),
    .head_valid_i   (chain_valid[`SLOT_COUNT]),
    .issue_ready_i  (issue_ready_i),
    .ext_redirect_i (ext_redirect),
    .head_ready_o   (chain_ready[`SLOT_COUNT]),
    .issue_o        (issue_o),
    .issue_valid_o  (issue_valid_o),
    .jal_o          (jal_redirect)
  );

endmodule

// File: test/tb_clock_gen.sv
module tb_clock_gen (
  input  logic rst_req_i,  // restart the reset sequence
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned hold_q = 3;

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    forever #4 clk_o = ~clk_o;  // 8 ns period
  end

  // reset stays low for three rising edges
  always @(posedge clk_o) begin
    if (rst_req_i) begin
      rst_n_o <= 1'b0;
      hold_q  <= 3;
    end else if (hold_q != 0) begin
      hold_q <= hold_q - 1;
      if (hold_q == 1) begin
        rst_n_o <= 1'b1;
      end
    end
  end

endmodule

// File: test/wb_imem_model.sv
`include "front_config.svh"

module wb_imem_model import front_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  wb_req_t          req_i,
  input  logic             jal_en_i,    // plant a jal at jal_adr_i
  input  logic [`XLEN-1:0] jal_adr_i,
  input  logic [31:0]      jal_word_i,
  output wb_rsp_t          rsp_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [1:0]  wait_q;
  logic        busy_q;
  logic [31:0] mem_word;
  int unsigned wait_draw;

  // addi x1, x0, imm with imm folded from every address bit
  function automatic logic [31:0] fill_word(input logic [`XLEN-1:0] adr);
    logic [11:0] imm;
    imm = adr[11:0] ^ adr[23:12] ^ adr[35:24] ^ adr[47:36] ^ adr[59:48] ^ {8'h00, adr[63:60]};
    return {imm, 5'd0, 3'b000, 5'd1, 7'b001_0011};
  endfunction

  assign mem_word = (jal_en_i && req_i.adr == jal_adr_i) ? jal_word_i : fill_word(req_i.adr);

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_o  <= '0;
      busy_q <= 1'b0;
      wait_q <= 2'd0;
    end else begin
      rsp_o.ack <= 1'b0;  // single cycle ack
      if (req_i.cyc && req_i.stb && !rsp_o.ack) begin
        if (!busy_q) begin
          wait_draw = $urandom_range(3, 0);
          if (wait_draw == 0) begin
            rsp_o.ack <= 1'b1;
            rsp_o.dat <= mem_word;
          end else begin
            busy_q <= 1'b1;
            wait_q <= 2'(wait_draw);
          end
        end else if (wait_q == 2'd1) begin
          rsp_o.ack <= 1'b1;
          rsp_o.dat <= mem_word;
          busy_q    <= 1'b0;
        end else begin
          wait_q <= wait_q - 2'd1;
        end
      end
    end
  end

endmodule

// File: test/front_end_tb.sv
`include "front_config.svh"

module front_end_tb
  import front_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum int {RK_NONE, RK_BRANCH, RK_TRAP, RK_FENCEI, RK_BOTH} redir_kind_e;

  typedef struct {
    string            name;
    logic             jal_en;
    logic [`XLEN-1:0] jal_adr;
    logic [20:0]      jal_off;
    redir_kind_e      kind;
    logic [`XLEN-1:0] target;
    int               wait_issues;  // issues seen before the redirect
    int               length;       // issues checked in this row
    logic             stall;        // random issue ready
  } row_t;

  row_t             rows[$];
  logic [`XLEN-1:0] exp_pc[$];

  logic             clk;
  logic             rst_n;
  logic             reset_req;
  redirect_t        branch;
  trap_redirect_t   trap;
  wb_req_t          wb_req;
  wb_rsp_t          wb_rsp;
  fetch_pkt_t       issue;
  logic             issue_valid;
  logic             issue_ready;
  logic             jal_en;
  logic [`XLEN-1:0] jal_adr;
  logic [31:0]      jal_word;
  logic             req_seen;
  int               errors = 0;
  int               checks = 0;
  int unsigned      cycle_cnt = 0;
  int unsigned      cycle_limit = 0;

  tb_clock_gen u_clk_gen (.rst_req_i(reset_req), .clk_o(clk), .rst_n_o(rst_n));

  wb_imem_model u_imem (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .req_i      (wb_req),
    .jal_en_i   (jal_en),
    .jal_adr_i  (jal_adr),
    .jal_word_i (jal_word),
    .rsp_o      (wb_rsp)
  );

  front_end_top UUT (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .branch_i      (branch),
    .trap_i        (trap),
    .wb_req_o      (wb_req),
    .wb_rsp_i      (wb_rsp),
    .issue_o       (issue),
    .issue_valid_o (issue_valid),
    .issue_ready_i (issue_ready)
  );

  // J-type word with rd = x1
  function automatic logic [31:0] jal_encode(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b110_1111};
  endfunction

  function automatic logic [31:0] expected_instr(input row_t r, input logic [`XLEN-1:0] pc);
    logic [11:0] imm;
    imm = pc[11:0] ^ pc[23:12] ^ pc[35:24] ^ pc[47:36] ^ pc[59:48] ^ {8'h00, pc[63:60]};
    if (r.jal_en && pc == r.jal_adr) begin
      return jal_encode(r.jal_off);
    end
    return {imm, 5'd0, 3'b000, 5'd1, 7'b001_0011};  // addi filler
  endfunction

  task automatic add_row(input string name, input logic jal_en_r, input logic [`XLEN-1:0] adr,
                         input logic [20:0] off, input redir_kind_e kind,
                         input logic [`XLEN-1:0] target, input int wait_issues,
                         input int length, input logic stall);
    row_t r;
    r.name        = name;
    r.jal_en      = jal_en_r;
    r.jal_adr     = adr;
    r.jal_off     = off;
    r.kind        = kind;
    r.target      = target;
    r.wait_issues = wait_issues;
    r.length      = length;
    r.stall       = stall;
    rows.push_back(r);
  endtask

  // pc stream from reset, jal jumps and the one redirect
  task automatic build_expected(input row_t r);
    logic [`XLEN-1:0] pc;
    exp_pc.delete();
    pc = `PC_RESET_ADDR;
    for (int i = 0; i < r.length; i++) begin
      if (r.kind != RK_NONE && i == r.wait_issues) begin
        pc = (r.kind == RK_FENCEI) ? r.target + 64'd4 : r.target;
      end
      exp_pc.push_back(pc);
      if (r.jal_en && pc == r.jal_adr) begin
        pc = pc + {{(`XLEN - 21){r.jal_off[20]}}, r.jal_off};
      end else begin
        pc = pc + 64'd4;
      end
    end
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [63:0] expected, input logic [63:0] actual);
    checks++;
    assert (expected == actual)
      else begin
        errors++;
        $display("error %s %s: expected %h, actual %h", test, what, expected, actual);
      end
  endtask

  task automatic drive_redirect(input row_t r, input logic on);
    branch <= '0;
    trap   <= '0;
    if (on) begin
      case (r.kind)
        RK_BRANCH: branch <= '{valid: 1'b1, target: r.target};
        RK_TRAP:   trap <= '{valid: 1'b1, fencei: 1'b0, target: r.target};
        RK_FENCEI: trap <= '{valid: 1'b1, fencei: 1'b1, target: r.target};
        RK_BOTH: begin
          trap   <= '{valid: 1'b1, fencei: 1'b0, target: r.target};
          branch <= '{valid: 1'b1, target: r.target + 64'h100};  // must lose
        end
        default: ;
      endcase
    end
  endtask

  task automatic run_row(input row_t r);
    int   issued;
    logic hs;
    build_expected(r);
    @(posedge clk);
    jal_en    <= r.jal_en;
    jal_adr   <= r.jal_adr;
    jal_word  <= jal_encode(r.jal_off);
    drive_redirect(r, 1'b0);
    reset_req <= 1'b1;
    @(posedge clk);
    reset_req <= 1'b0;
    @(negedge clk);
    while (!rst_n) begin
      checks++;
      assert (!wb_req.cyc && !wb_req.stb && !issue_valid)
        else begin
          errors++;
          $display("%s: bus cycle or issue valid seen while reset was asserted", r.name);
        end
      @(negedge clk);
    end
    req_seen = 1'b0;
    issued   = 0;
    while (issued < r.length) begin
      hs = issue_valid && issue_ready;  // stable at the falling edge
      if (!req_seen && wb_req.cyc) begin
        req_seen = 1'b1;
        check_value(r.name, "first adr", `PC_RESET_ADDR, wb_req.adr);
      end
      if (wb_req.cyc) begin
        // single word read on all byte lanes
        check_value(r.name, "stb we sel", 64'({1'b1, 1'b0, 4'hf}),
                    64'({wb_req.stb, wb_req.we, wb_req.sel}));
      end
      if (hs) begin
        check_value(r.name, "pc", exp_pc[issued], issue.pc);
        check_value(r.name, "instr", 64'(expected_instr(r, exp_pc[issued])), 64'(issue.instr));
        issued++;
      end
      @(posedge clk);
      drive_redirect(r, hs && r.kind != RK_NONE && issued == r.wait_issues);
      issue_ready <= r.stall ? ($urandom_range(3, 0) != 0) : 1'b1;
      @(negedge clk);
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: issue stream stopped making progress after %0d cycles", cycle_cnt);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    void'($urandom(3788));
    reset_req   = 1'b0;
    branch      = '0;
    trap        = '0;
    issue_ready = 1'b1;
    jal_en      = 1'b0;
    jal_adr     = '0;
    jal_word    = '0;

    //      name               jal   jal pc          offset      kind       target        n  len stall
    add_row("reset_seq",       1'b0, 64'h0,          21'h0,      RK_NONE,   64'h0,         0, 12, 1'b0);
    add_row("jal_fwd",         1'b1, 64'h8000_0010,  21'h40,     RK_NONE,   64'h0,         0, 12, 1'b0);
    add_row("jal_back",        1'b1, 64'h8000_0020,  -21'sd24,   RK_NONE,   64'h0,         0, 16, 1'b0);
    add_row("branch",          1'b0, 64'h0,          21'h0,      RK_BRANCH, 64'h8000_1000, 5, 12, 1'b0);
    add_row("trap",            1'b0, 64'h0,          21'h0,      RK_TRAP,   64'h8000_2000, 3, 10, 1'b0);
    add_row("trap_fencei",     1'b0, 64'h0,          21'h0,      RK_FENCEI, 64'h8000_3000, 6, 10, 1'b0);
    add_row("trap_and_branch", 1'b0, 64'h0,          21'h0,      RK_BOTH,   64'h8000_4000, 4, 10, 1'b0);
    add_row("backpressure",    1'b1, 64'h8000_000c,  21'h100,    RK_BRANCH, 64'h8000_5000, 7, 20, 1'b1);
    add_row("bp_seq",          1'b0, 64'h0,          21'h0,      RK_NONE,   64'h0,         0, 24, 1'b1);
    add_row("jal_then_branch", 1'b1, 64'h8000_0008,  21'h20,     RK_BRANCH, 64'h8000_6000, 3, 10, 1'b1);

    foreach (rows[i]) begin
      cycle_limit += 40 * rows[i].length + 16;  // reset and setup per row
    end
    foreach (rows[i]) begin
      run_row(rows[i]);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+src
src/front_pkg.sv
src/pc_gen.sv
src/fetch_wb_master.sv
src/pipe_slot.sv
src/jal_predecode.sv
src/front_end_top.sv
test/tb_clock_gen.sv
test/wb_imem_model.sv
test/front_end_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/100ps -j 0
TOP       := front_end_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
